/* hw/vi_isa_pkg.sv */
// Instruction set definitions: data and register widths, opcodes, instruction format
package vi_isa_pkg;

	localparam int xlen = 32;
	localparam int reg_addr_w = 5;
	localparam int imm_w = 13;

	typedef enum logic [3:0] {
		NOP = 4'd0,
		ADD = 4'd1,
		SUB = 4'd2,
		AND = 4'd3,
		OR  = 4'd4,
		XOR = 4'd5,
		SLL = 4'd6,
		MUL = 4'd7,
		LI  = 4'd8
	} opcode_t;

	// Msb first, 32 bits in total
	typedef struct packed {
		opcode_t                 op;
		logic [reg_addr_w-1:0]   rd;
		logic [reg_addr_w-1:0]   rs1;
		logic [reg_addr_w-1:0]   rs2;
		logic signed [imm_w-1:0] imm;
	} instr_t;

endpackage

/* hw/vi_pipe_pkg.sv */
// Pipeline stage structs: fetch entry, execute operation, write-back and forwarding
package vi_pipe_pkg;

	typedef struct packed {
		vi_isa_pkg::instr_t            instr;
		logic [vi_isa_pkg::xlen-1:0]   pc;
	} fetch_t;

	typedef struct packed {
		logic                              valid;
		vi_isa_pkg::opcode_t               op;
		logic [vi_isa_pkg::xlen-1:0]       pc;
		logic [vi_isa_pkg::reg_addr_w-1:0] rd;
		logic                              we;
		logic [vi_isa_pkg::xlen-1:0]       a;
		logic [vi_isa_pkg::xlen-1:0]       b;
	} exe_op_t;

	// Rd is zero for instructions that write no register
	typedef struct packed {
		logic                              valid;
		logic [vi_isa_pkg::xlen-1:0]       pc;
		logic [vi_isa_pkg::reg_addr_w-1:0] rd;
		logic [vi_isa_pkg::xlen-1:0]       data;
	} wb_t;

	typedef struct packed {
		logic                              valid;
		logic [vi_isa_pkg::reg_addr_w-1:0] rd;
		logic [vi_isa_pkg::xlen-1:0]       data;
	} fwd_t;

endpackage

/* hw/fetch.sv */
// Fetch stage: input handshake, pc counter and the entry register feeding decode
`timescale 1ns/1ns

module fetch (
	input  logic                clk_i,
	input  logic                rst_n_i,
	input  logic                in_valid_i,
	input  vi_isa_pkg::instr_t  in_instr_i,
	output logic                in_ready_o,
	input  logic                stall_i,
	output vi_pipe_pkg::fetch_t dec_o,
	output logic                dec_valid_o
);

	logic run_q;
	logic valid_q;
	logic accept;
	logic [vi_isa_pkg::xlen-1:0] pc_q;
	vi_pipe_pkg::fetch_t entry_q;

	// Entry is free when empty or when it moves on this cycle
	assign in_ready_o = run_q && (!valid_q || !stall_i);
	assign accept = in_valid_i && in_ready_o;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			run_q <= 1'b0;
			valid_q <= 1'b0;
			pc_q <= '0;
		end else begin
			run_q <= 1'b1;
			valid_q <= accept || (valid_q && stall_i);
			if (accept) begin
				pc_q <= pc_q + 32'd4;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (accept) begin
			entry_q <= '{instr: in_instr_i, pc: pc_q};
		end
	end

	assign dec_o = entry_q;
	assign dec_valid_o = valid_q;

	// A stalled instruction is still held, unchanged, one cycle later
	a_hold_on_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		stall_i |=> valid_q && $stable(entry_q));

endmodule

/* hw/decoder.sv */
// Decode stage: field split, operand select, immediate extension and the execute register
`timescale 1ns/1ns

module decoder (
	input  logic                                  clk_i,
	input  logic                                  rst_n_i,
	input  vi_pipe_pkg::fetch_t                   dec_i,
	input  logic                                  dec_valid_i,
	input  logic                                  stall_i,
	output logic [vi_isa_pkg::reg_addr_w-1:0]     rs1_o,
	output logic [vi_isa_pkg::reg_addr_w-1:0]     rs2_o,
	input  logic [vi_isa_pkg::xlen-1:0]           reg_a_i,
	input  logic [vi_isa_pkg::xlen-1:0]           reg_b_i,
	input  logic                                  byp_a_en_i,
	input  logic                                  byp_b_en_i,
	input  logic [vi_isa_pkg::xlen-1:0]           byp_a_i,
	input  logic [vi_isa_pkg::xlen-1:0]           byp_b_i,
	output logic                                  op_is_mul_o,
	output logic                                  op_is_alu_o,
	output vi_pipe_pkg::exe_op_t                  exe_o
);

	vi_isa_pkg::instr_t instr;
	logic [vi_isa_pkg::xlen-1:0] imm_ext;
	logic [vi_isa_pkg::xlen-1:0] opnd_a;
	logic [vi_isa_pkg::xlen-1:0] opnd_b;
	vi_pipe_pkg::exe_op_t exe_d;
	vi_pipe_pkg::exe_op_t exe_q;

	assign instr = dec_i.instr;
	assign rs1_o = instr.rs1;
	assign rs2_o = instr.rs2;

	// NOP counts as an ALU op since it still takes the write-back slot
	assign op_is_mul_o = dec_valid_i && (instr.op == vi_isa_pkg::MUL);
	assign op_is_alu_o = dec_valid_i && (instr.op != vi_isa_pkg::MUL);

	assign imm_ext = {{(vi_isa_pkg::xlen - vi_isa_pkg::imm_w){instr.imm[vi_isa_pkg::imm_w-1]}},
		instr.imm};
	assign opnd_a = byp_a_en_i ? byp_a_i : reg_a_i;
	assign opnd_b = byp_b_en_i ? byp_b_i : reg_b_i;

	always_comb begin
		exe_d.valid = dec_valid_i && !stall_i;
		exe_d.op = instr.op;
		exe_d.pc = dec_i.pc;
		exe_d.rd = instr.rd;
		exe_d.we = (instr.op != vi_isa_pkg::NOP);
		exe_d.a = opnd_a;
		exe_d.b = (instr.op == vi_isa_pkg::LI) ? imm_ext : opnd_b;
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			exe_q.valid <= 1'b0;
		end else begin
			exe_q <= exe_d;
		end
	end

	assign exe_o = exe_q;

endmodule

/* hw/int_registers.sv */
// Integer register file: two asynchronous reads, one write, r0 reads zero
`timescale 1ns/1ns

module int_registers (
	input  logic                              clk_i,
	input  logic                              rst_n_i,
	input  logic [vi_isa_pkg::reg_addr_w-1:0] rs1_i,
	input  logic [vi_isa_pkg::reg_addr_w-1:0] rs2_i,
	input  vi_pipe_pkg::wb_t                  wb_i,
	output logic [vi_isa_pkg::xlen-1:0]       rd_a_o,
	output logic [vi_isa_pkg::xlen-1:0]       rd_b_o
);

	logic [vi_isa_pkg::xlen-1:0] regs [1:31];

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_i.valid && (wb_i.rd != '0)) begin
			regs[wb_i.rd] <= wb_i.data;
		end
	end

	assign rd_a_o = (rs1_i == '0) ? '0 : regs[rs1_i];
	assign rd_b_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

/* hw/bypass_ctrl.sv */
// Bypass and hazard control: operand forwarding select and decode stall
`timescale 1ns/1ns

module bypass_ctrl #(
	parameter int MUL_STAGES = 3
) (
	input  logic                              clk_i,
	input  logic                              rst_n_i,
	input  logic [vi_isa_pkg::reg_addr_w-1:0] rs1_i,
	input  logic [vi_isa_pkg::reg_addr_w-1:0] rs2_i,
	input  logic                              op_is_mul_i,
	input  logic                              op_is_alu_i,
	input  logic                              dec_valid_i,
	input  vi_pipe_pkg::exe_op_t              exe_i,
	input  vi_pipe_pkg::fwd_t                 alu_fwd_i,
	input  vi_pipe_pkg::fwd_t                 mul_fwd_i,
	input  vi_pipe_pkg::wb_t                  wb_i,
	input  logic [MUL_STAGES-1:0]             mul_busy_i,
	output logic                              byp_a_en_o,
	output logic                              byp_b_en_o,
	output logic [vi_isa_pkg::xlen-1:0]       byp_a_o,
	output logic [vi_isa_pkg::xlen-1:0]       byp_b_o,
	output logic                              stall_o
);

	logic [vi_isa_pkg::reg_addr_w-1:0] rd_q [MUL_STAGES];
	logic exe_mul;
	logic raw_mul;
	logic order_mul;
	vi_pipe_pkg::fwd_t sel_a;
	vi_pipe_pkg::fwd_t sel_b;

	// Youngest matching producer wins
	function automatic vi_pipe_pkg::fwd_t pick(
		input logic [vi_isa_pkg::reg_addr_w-1:0] rs,
		input vi_pipe_pkg::fwd_t alu,
		input vi_pipe_pkg::fwd_t mul,
		input vi_pipe_pkg::wb_t wb
	);
		vi_pipe_pkg::fwd_t res;
		res.valid = 1'b1;
		res.rd = rs;
		if (alu.valid && (alu.rd == rs)) begin
			res.data = alu.data;
		end else if (mul.valid && (mul.rd == rs)) begin
			res.data = mul.data;
		end else if (wb.valid && (wb.rd != '0) && (wb.rd == rs)) begin
			res.data = wb.data;
		end else begin
			res.valid = 1'b0;
			res.data = '0;
		end
		return res;
	endfunction

	function automatic logic reads(input logic [vi_isa_pkg::reg_addr_w-1:0] rd);
		return (rd != '0) && ((rd == rs1_i) || (rd == rs2_i));
	endfunction

	assign sel_a = pick(rs1_i, alu_fwd_i, mul_fwd_i, wb_i);
	assign sel_b = pick(rs2_i, alu_fwd_i, mul_fwd_i, wb_i);
	assign byp_a_en_o = sel_a.valid;
	assign byp_b_en_o = sel_b.valid;
	assign byp_a_o = sel_a.data;
	assign byp_b_o = sel_b.data;

	// Destination copy of each multiplier stage
	always_ff @(posedge clk_i) begin
		rd_q[0] <= exe_i.rd;
		for (int j = 1; j < MUL_STAGES; j++) begin
			rd_q[j] <= rd_q[j-1];
		end
	end

	assign exe_mul = exe_i.valid && (exe_i.op == vi_isa_pkg::MUL);

	// MULs in execute or before the last stage cannot forward yet
	always_comb begin
		raw_mul = exe_mul && reads(exe_i.rd);
		order_mul = exe_mul;
		for (int j = 0; j < MUL_STAGES - 1; j++) begin
			raw_mul = raw_mul || (mul_busy_i[j] && reads(rd_q[j]));
			order_mul = order_mul || mul_busy_i[j];
		end
	end

	// ALU ops wait behind such MULs, which frees the write port and keeps writes in order
	assign stall_o = (op_is_alu_i && order_mul) || (op_is_mul_i && raw_mul);

	a_stall_in_decode: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		stall_o |-> dec_valid_i);

endmodule

/* hw/exe_unit.sv */
// Execute stage: ALU, multiplier shift pipeline and the write-back register
`timescale 1ns/1ns

module exe_unit #(
	parameter int MUL_STAGES = 3
) (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  vi_pipe_pkg::exe_op_t  exe_i,
	output vi_pipe_pkg::fwd_t     alu_fwd_o,
	output vi_pipe_pkg::fwd_t     mul_fwd_o,
	output logic [MUL_STAGES-1:0] mul_busy_o,
	output vi_pipe_pkg::wb_t      wb_o
);

	logic is_mul;
	logic alu_done;
	logic mul_done;
	logic [vi_isa_pkg::xlen-1:0] alu_res;
	logic [vi_isa_pkg::xlen-1:0] mul_lo;
	vi_pipe_pkg::wb_t mul_q [MUL_STAGES];
	vi_pipe_pkg::wb_t wb_q;

	assign is_mul = (exe_i.op == vi_isa_pkg::MUL);
	assign alu_done = exe_i.valid && !is_mul;
	assign mul_done = mul_q[MUL_STAGES-1].valid;

	always_comb begin
		case (exe_i.op)
			vi_isa_pkg::ADD: alu_res = exe_i.a + exe_i.b;
			vi_isa_pkg::SUB: alu_res = exe_i.a - exe_i.b;
			vi_isa_pkg::AND: alu_res = exe_i.a & exe_i.b;
			vi_isa_pkg::OR:  alu_res = exe_i.a | exe_i.b;
			vi_isa_pkg::XOR: alu_res = exe_i.a ^ exe_i.b;
			vi_isa_pkg::SLL: alu_res = exe_i.a << exe_i.b[4:0];
			vi_isa_pkg::LI:  alu_res = exe_i.b;
			default:         alu_res = '0;
		endcase
	end

	// Low half of the product only
	assign mul_lo = exe_i.a * exe_i.b;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			for (int j = 0; j < MUL_STAGES; j++) begin
				mul_q[j].valid <= 1'b0;
			end
		end else begin
			mul_q[0] <= '{valid: exe_i.valid && is_mul, pc: exe_i.pc, rd: exe_i.rd,
				data: mul_lo};
			for (int j = 1; j < MUL_STAGES; j++) begin
				mul_q[j] <= mul_q[j-1];
			end
		end
	end

	always_comb begin
		for (int j = 0; j < MUL_STAGES; j++) begin
			mul_busy_o[j] = mul_q[j].valid;
		end
	end

	always_comb begin
		alu_fwd_o.valid = alu_done && exe_i.we && (exe_i.rd != '0);
		alu_fwd_o.rd = exe_i.rd;
		alu_fwd_o.data = alu_res;
		mul_fwd_o.valid = mul_done && (mul_q[MUL_STAGES-1].rd != '0);
		mul_fwd_o.rd = mul_q[MUL_STAGES-1].rd;
		mul_fwd_o.data = mul_q[MUL_STAGES-1].data;
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			wb_q.valid <= 1'b0;
		end else if (mul_done) begin
			wb_q <= mul_q[MUL_STAGES-1];
		end else begin
			wb_q.valid <= alu_done;
			wb_q.pc <= exe_i.pc;
			wb_q.rd <= exe_i.we ? exe_i.rd : '0;
			wb_q.data <= alu_res;
		end
	end

	assign wb_o = wb_q;

	// Decode stall keeps the ALU and multiplier off the write port together
	a_one_writer: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!(alu_done && mul_done));

endmodule

/* hw/vi_core.sv */
// Core top level: fetch, decode, register file, bypass control and execute
`timescale 1ns/1ns

module vi_core #(
	parameter int MUL_STAGES = 3
) (
	input  logic               clk_i,
	input  logic               rst_n_i,
	input  logic               in_valid_i,
	input  vi_isa_pkg::instr_t in_instr_i,
	output logic               in_ready_o,
	output vi_pipe_pkg::wb_t   retire_o
);

	// Fetch to decode
	vi_pipe_pkg::fetch_t dec_entry;
	logic dec_valid;
	logic stall;

	// Decode operands
	logic [vi_isa_pkg::reg_addr_w-1:0] rs1;
	logic [vi_isa_pkg::reg_addr_w-1:0] rs2;
	logic [vi_isa_pkg::xlen-1:0] reg_a;
	logic [vi_isa_pkg::xlen-1:0] reg_b;
	logic byp_a_en;
	logic byp_b_en;
	logic [vi_isa_pkg::xlen-1:0] byp_a;
	logic [vi_isa_pkg::xlen-1:0] byp_b;
	logic op_is_mul;
	logic op_is_alu;

	// Execute and write-back
	vi_pipe_pkg::exe_op_t exe_op;
	vi_pipe_pkg::fwd_t alu_fwd;
	vi_pipe_pkg::fwd_t mul_fwd;
	logic [MUL_STAGES-1:0] mul_busy;
	vi_pipe_pkg::wb_t wb;

	fetch fetch (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.in_valid_i  (in_valid_i),
		.in_instr_i  (in_instr_i),
		.in_ready_o  (in_ready_o),
		.stall_i     (stall),
		.dec_o       (dec_entry),
		.dec_valid_o (dec_valid)
	);

	decoder decoder (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.dec_i       (dec_entry),
		.dec_valid_i (dec_valid),
		.stall_i     (stall),
		.rs1_o       (rs1),
		.rs2_o       (rs2),
		.reg_a_i     (reg_a),
		.reg_b_i     (reg_b),
		.byp_a_en_i  (byp_a_en),
		.byp_b_en_i  (byp_b_en),
		.byp_a_i     (byp_a),
		.byp_b_i     (byp_b),
		.op_is_mul_o (op_is_mul),
		.op_is_alu_o (op_is_alu),
		.exe_o       (exe_op)
	);

	int_registers int_registers (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.rs1_i   (rs1),
		.rs2_i   (rs2),
		.wb_i    (wb),
		.rd_a_o  (reg_a),
		.rd_b_o  (reg_b)
	);

	bypass_ctrl #(
		.MUL_STAGES (MUL_STAGES)
	) bypass_ctrl (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.rs1_i       (rs1),
		.rs2_i       (rs2),
		.op_is_mul_i (op_is_mul),
		.op_is_alu_i (op_is_alu),
		.dec_valid_i (dec_valid),
		.exe_i       (exe_op),
		.alu_fwd_i   (alu_fwd),
		.mul_fwd_i   (mul_fwd),
		.wb_i        (wb),
		.mul_busy_i  (mul_busy),
		.byp_a_en_o  (byp_a_en),
		.byp_b_en_o  (byp_b_en),
		.byp_a_o     (byp_a),
		.byp_b_o     (byp_b),
		.stall_o     (stall)
	);

	exe_unit #(
		.MUL_STAGES (MUL_STAGES)
	) exe_unit (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.exe_i      (exe_op),
		.alu_fwd_o  (alu_fwd),
		.mul_fwd_o  (mul_fwd),
		.mul_busy_o (mul_busy),
		.wb_o       (wb)
	);

	assign retire_o = wb;

endmodule

/* dv/vi_core_tb.sv */
// Core testbench: random program stimulus, in-order reference model, retire checker, watchdog
`timescale 1ns/1ns

module vi_core_tb;

	localparam int MUL_STAGES = 3;
	localparam int NUM_INSTR = 400;
	localparam int CLK_PERIOD = 4;
	localparam int TIMEOUT_NS = NUM_INSTR * (MUL_STAGES + 6) * CLK_PERIOD;
	// Longest drain is a MUL held behind another MUL
	localparam int DRAIN_CYCLES = 2 * MUL_STAGES + 8;

	logic clk_i;
	logic rst_n_i;
	logic in_valid_i;
	vi_isa_pkg::instr_t in_instr_i;
	logic in_ready_o;
	vi_pipe_pkg::wb_t retire_o;

	integer seed;
	int accepted_cnt;
	int retired_cnt;
	logic [31:0] model_pc;
	logic [31:0] model_regs [32];
	// Expected destination and result, keyed by pc
	logic [4:0] exp_rd [logic [31:0]];
	logic [31:0] exp_data [logic [31:0]];

	vi_core #(
		.MUL_STAGES (MUL_STAGES)
	) UUT (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.in_valid_i (in_valid_i),
		.in_instr_i (in_instr_i),
		.in_ready_o (in_ready_o),
		.retire_o   (retire_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
	end

	task automatic report_error(input string msg);
		$display("Error at %0t ns: %s", $time, msg);
		$display("TESTS FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	// Executes one instruction in program order and records what it must retire with
	task automatic model_accept(input vi_isa_pkg::instr_t instr);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic [4:0] rd;
		a = model_regs[instr.rs1];
		b = model_regs[instr.rs2];
		case (instr.op)
			vi_isa_pkg::ADD: res = a + b;
			vi_isa_pkg::SUB: res = a - b;
			vi_isa_pkg::AND: res = a & b;
			vi_isa_pkg::OR:  res = a | b;
			vi_isa_pkg::XOR: res = a ^ b;
			vi_isa_pkg::SLL: res = a << b[4:0];
			vi_isa_pkg::MUL: res = a * b;
			vi_isa_pkg::LI:  res = {{19{instr.imm[12]}}, instr.imm};
			default:         res = 32'd0;
		endcase
		rd = (instr.op == vi_isa_pkg::NOP) ? 5'd0 : instr.rd;
		// r0 stays zero whatever is written to it
		if (rd != 5'd0) begin
			model_regs[rd] = res;
		end
		exp_rd[model_pc] = rd;
		exp_data[model_pc] = res;
		model_pc = model_pc + 32'd4;
		accepted_cnt++;
	endtask

	task automatic draw_instr(output vi_isa_pkg::instr_t instr);
		int sel;
		sel = $unsigned($random(seed)) % 12;
		// Extra weight on LI keeps register values varied
		instr.op = (sel > 8) ? vi_isa_pkg::LI : vi_isa_pkg::opcode_t'(sel);
		// Only r0 to r5, so hazards are frequent
		instr.rd = 5'($unsigned($random(seed)) % 6);
		instr.rs1 = 5'($unsigned($random(seed)) % 6);
		instr.rs2 = 5'($unsigned($random(seed)) % 6);
		instr.imm = 13'($random(seed));
	endtask

	// Holds the instruction stable until the core takes it
	task automatic send(input vi_isa_pkg::instr_t instr);
		logic taken;
		taken = 1'b0;
		in_valid_i <= 1'b1;
		in_instr_i <= instr;
		while (!taken) begin
			@(negedge clk_i);
			taken = in_valid_i && in_ready_o;
			@(posedge clk_i);
		end
		model_accept(instr);
	endtask

	initial begin
		vi_isa_pkg::instr_t instr;
		int idle;
		int drain;
		seed = 32'h35c6;
		accepted_cnt = 0;
		retired_cnt = 0;
		model_pc = 32'd0;
		for (int i = 0; i < 32; i++) begin
			model_regs[i] = 32'd0;
		end
		rst_n_i = 1'b0;
		in_valid_i = 1'b0;
		in_instr_i = '0;
		repeat (5) @(posedge clk_i);
		rst_n_i <= 1'b1;
		for (int n = 0; n < NUM_INSTR; n++) begin
			draw_instr(instr);
			idle = 0;
			if ($unsigned($random(seed)) % 4 == 0) begin
				idle = 1 + $unsigned($random(seed)) % 2;
			end
			if (idle > 0) begin
				in_valid_i <= 1'b0;
				repeat (idle) @(posedge clk_i);
			end
			send(instr);
		end
		in_valid_i <= 1'b0;
		drain = 0;
		while ((retired_cnt != accepted_cnt) && (drain < DRAIN_CYCLES)) begin
			@(posedge clk_i);
			drain++;
		end
		// Extra cycles so a late duplicate retire would still be seen
		repeat (MUL_STAGES + 4) @(posedge clk_i);
		assert (retired_cnt == accepted_cnt && exp_rd.num() == 0) begin
			$display("TESTS PASSED");
			$finish;
		end else begin
			report_error($sformatf("retired %0d of %0d accepted instructions",
				retired_cnt, accepted_cnt));
		end
	end

	always @(negedge clk_i) begin
		if (!rst_n_i) begin
			assert (!in_ready_o && !retire_o.valid)
			else report_error("core is not idle while reset is held");
		end else if (retire_o.valid) begin
			assert (exp_rd.exists(retire_o.pc))
			else report_error($sformatf("pc 0x%h retired but is unknown or already retired",
				retire_o.pc));
			assert (retire_o.rd == exp_rd[retire_o.pc])
			else report_error($sformatf("pc 0x%h retired rd %0d, expected %0d",
				retire_o.pc, retire_o.rd, exp_rd[retire_o.pc]));
			assert (retire_o.data == exp_data[retire_o.pc])
			else report_error($sformatf("pc 0x%h retired data 0x%h, expected 0x%h",
				retire_o.pc, retire_o.data, exp_data[retire_o.pc]));
			exp_rd.delete(retire_o.pc);
			exp_data.delete(retire_o.pc);
			retired_cnt++;
		end
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the program did not drain within %0d ns", TIMEOUT_NS);
		$display("TESTS FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

/* verilog.f */
hw/vi_isa_pkg.sv
hw/vi_pipe_pkg.sv
hw/fetch.sv
hw/decoder.sv
hw/int_registers.sv
hw/bypass_ctrl.sv
hw/exe_unit.sv
hw/vi_core.sv
dv/vi_core_tb.sv
